//--- logic/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define ALU_WORD_WIDTH  32
`define ALU_QUEUE_DEPTH 4   // also the source's starting credits
`define ALU_RSP_CREDITS 2   // sink slots granted at reset

`define ALU_OPC_RTYPE 6'b000000
`define ALU_OPC_BEQ   6'b000100
`define ALU_OPC_BNE   6'b000101
`define ALU_OPC_ADDI  6'b001000
`define ALU_OPC_ADDIU 6'b001001
`define ALU_OPC_SLTI  6'b001010
`define ALU_OPC_SLTIU 6'b001011
`define ALU_OPC_ANDI  6'b001100
`define ALU_OPC_ORI   6'b001101
`define ALU_OPC_XORI  6'b001110

`define ALU_FN_SLL  6'b000000
`define ALU_FN_SRL  6'b000010
`define ALU_FN_SRA  6'b000011
`define ALU_FN_SLLV 6'b000100
`define ALU_FN_SRLV 6'b000110
`define ALU_FN_SRAV 6'b000111
`define ALU_FN_ADD  6'b100000
`define ALU_FN_ADDU 6'b100001
`define ALU_FN_SUB  6'b100010
`define ALU_FN_SUBU 6'b100011
`define ALU_FN_AND  6'b100100
`define ALU_FN_OR   6'b100101
`define ALU_FN_XOR  6'b100110
`define ALU_FN_NOR  6'b100111
`define ALU_FN_SLT  6'b101010
`define ALU_FN_SLTU 6'b101011

`endif

//--- logic/alu_pkg.sv
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

    typedef enum logic [4:0] {
        aluNop,     // unlisted opcode or funct
        aluAdd,
        aluAddu,
        aluSub,
        aluSubu,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluSllv,
        aluSrlv,
        aluSrav,
        aluAddi,
        aluAddiu,
        aluAndi,
        aluOri,
        aluXori,
        aluSlti,
        aluSltiu,
        aluBeq,
        aluBne
    } aluOp_e;

    typedef struct packed {
        logic [`ALU_WORD_WIDTH-1:0] instr;
        logic [`ALU_WORD_WIDTH-1:0] regA;
        logic [`ALU_WORD_WIDTH-1:0] regB;
    } aluReq_t;

    typedef struct packed {
        aluOp_e                     op;
        logic [`ALU_WORD_WIDTH-1:0] opA;
        logic [`ALU_WORD_WIDTH-1:0] opB;   // extended immediate for I-type
        logic [4:0]                 shamt;
    } decodedOp_t;

    typedef struct packed {
        logic overflow;
        logic negative;
        logic zero;
    } aluFlags_t;

    typedef struct packed {
        logic [`ALU_WORD_WIDTH-1:0] result;
        aluFlags_t                  flags;
    } aluRsp_t;

endpackage

`default_nettype wire

//--- logic/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_macros.svh"

module instr_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                reqValid,
    input  alu_pkg::aluReq_t    req,
    output logic                decValid,
    output alu_pkg::decodedOp_t dec
);
    import alu_pkg::*;

    logic [5:0]                 opcode;
    logic [5:0]                 funct;
    logic [4:0]                 rs;
    logic [4:0]                 rt;
    logic [4:0]                 shamt;
    logic [15:0]                imm;
    logic [`ALU_WORD_WIDTH-1:0] selA;
    logic [`ALU_WORD_WIDTH-1:0] selB;
    logic [`ALU_WORD_WIDTH-1:0] immSext;
    logic [`ALU_WORD_WIDTH-1:0] immZext;
    aluOp_e                     op;
    decodedOp_t                 decNext;

    assign opcode = req.instr[31:26];
    assign rs     = req.instr[25:21];
    assign rt     = req.instr[20:16];
    assign shamt  = req.instr[10:6];
    assign funct  = req.instr[5:0];
    assign imm    = req.instr[15:0];

    assign selA    = rs[0] ? req.regB : req.regA;   // bit 0 picks the register
    assign selB    = rt[0] ? req.regB : req.regA;
    assign immSext = {{(`ALU_WORD_WIDTH-16){imm[15]}}, imm};
    assign immZext = {{(`ALU_WORD_WIDTH-16){1'b0}}, imm};

    always_comb begin
        op = aluNop;
        case (opcode)
            `ALU_OPC_RTYPE: begin
                case (funct)
                    `ALU_FN_ADD:  op = aluAdd;
                    `ALU_FN_ADDU: op = aluAddu;
                    `ALU_FN_SUB:  op = aluSub;
                    `ALU_FN_SUBU: op = aluSubu;
                    `ALU_FN_AND:  op = aluAnd;
                    `ALU_FN_OR:   op = aluOr;
                    `ALU_FN_XOR:  op = aluXor;
                    `ALU_FN_NOR:  op = aluNor;
                    `ALU_FN_SLT:  op = aluSlt;
                    `ALU_FN_SLTU: op = aluSltu;
                    `ALU_FN_SLL:  op = aluSll;
                    `ALU_FN_SRL:  op = aluSrl;
                    `ALU_FN_SRA:  op = aluSra;
                    `ALU_FN_SLLV: op = aluSllv;
                    `ALU_FN_SRLV: op = aluSrlv;
                    `ALU_FN_SRAV: op = aluSrav;
                    default:      op = aluNop;
                endcase
            end
            `ALU_OPC_ADDI:  op = aluAddi;
            `ALU_OPC_ADDIU: op = aluAddiu;
            `ALU_OPC_ANDI:  op = aluAndi;
            `ALU_OPC_ORI:   op = aluOri;
            `ALU_OPC_XORI:  op = aluXori;
            `ALU_OPC_SLTI:  op = aluSlti;
            `ALU_OPC_SLTIU: op = aluSltiu;
            `ALU_OPC_BEQ:   op = aluBeq;
            `ALU_OPC_BNE:   op = aluBne;
            default:        op = aluNop;
        endcase
    end

    always_comb begin
        decNext.op    = op;
        decNext.opA   = selA;
        decNext.opB   = selB;
        decNext.shamt = shamt;
        case (op)
            aluAddi, aluAddiu, aluSlti, aluSltiu: decNext.opB = immSext;
            aluAndi, aluOri, aluXori:             decNext.opB = immZext;
            default:                              decNext.opB = selB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else begin
            decValid <= reqValid;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            dec <= decNext;
        end
    end

endmodule

`default_nettype wire

//--- logic/op_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_macros.svh"

module op_queue #(
    parameter int DEPTH = `ALU_QUEUE_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                decValid,
    input  alu_pkg::decodedOp_t dec,
    input  logic                pop,
    output logic                notEmpty,
    output alu_pkg::decodedOp_t head,
    output logic                reqCredit
);
    import alu_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    decodedOp_t       mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;   // wrap for non power of two depths
        end
        return ptr + PTR_W'(1);
    endfunction

    assign notEmpty = (count != '0);
    assign head     = mem[rdPtr];   // fall-through read

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            reqCredit <= 1'b0;
        end else begin
            if (decValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count     <= count + CNT_W'(decValid) - CNT_W'(pop);
            reqCredit <= pop;   // one credit back per pop
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            mem[wrPtr] <= dec;
        end
    end

endmodule

`default_nettype wire

//--- logic/alu_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_macros.svh"

module alu_execute (
    input  logic                clk,
    input  logic                rst,
    input  logic                notEmpty,
    input  alu_pkg::decodedOp_t head,
    output logic                pop,
    input  logic                rspCredit,
    output logic                rspValid,
    output alu_pkg::aluRsp_t    rsp
);
    import alu_pkg::*;

    localparam int CNT_W = $clog2(`ALU_RSP_CREDITS + 1);
    localparam int MSB   = `ALU_WORD_WIDTH - 1;

    logic [CNT_W-1:0] credits;
    logic [MSB:0]     opA;
    logic [MSB:0]     opB;
    logic [MSB:0]     sum;
    logic [MSB:0]     diff;
    logic [MSB:0]     result;
    logic [4:0]       varAmt;
    logic             ltSigned;
    logic             ltUnsigned;
    logic             addOvf;
    logic             subOvf;
    aluFlags_t        flags;

    assign pop = notEmpty && (credits != '0);   // only with a sink slot

    assign opA    = head.opA;
    assign opB    = head.opB;
    assign sum    = opA + opB;
    assign diff   = opA - opB;
    assign varAmt = opA[4:0];   // variable shift amount

    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;
    assign addOvf     = (opA[MSB] == opB[MSB]) && (sum[MSB] != opA[MSB]);
    assign subOvf     = (opA[MSB] != opB[MSB]) && (diff[MSB] != opA[MSB]);

    always_comb begin
        result = '0;
        flags  = '0;
        case (head.op)
            aluAdd, aluAddi: begin
                result         = sum;
                flags.overflow = addOvf;
            end
            aluAddu: begin
                result         = sum;
                flags.negative = sum[MSB];
            end
            aluAddiu: result = sum;
            aluSub: begin
                result         = diff;
                flags.overflow = subOvf;
            end
            aluSubu:          result = diff;
            aluAnd, aluAndi:  result = opA & opB;
            aluOr, aluOri:    result = opA | opB;
            aluXor, aluXori:  result = opA ^ opB;
            aluNor:           result = ~(opA | opB);
            aluSlt, aluSlti: begin
                result[0]      = ltSigned;
                flags.negative = ltSigned;
            end
            aluSltu, aluSltiu: begin
                result[0]      = ltUnsigned;
                flags.negative = ltUnsigned;
            end
            aluSll:  result = opB << head.shamt;
            aluSrl:  result = opB >> head.shamt;
            aluSra:  result = $signed(opB) >>> head.shamt;
            aluSllv: result = opB << varAmt;
            aluSrlv: result = opB >> varAmt;
            aluSrav: result = $signed(opB) >>> varAmt;
            aluBeq:  flags.zero = (opA == opB);   // result stays 0
            aluBne:  flags.zero = (opA != opB);
            default: begin
                result = '0;
                flags  = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits  <= CNT_W'(`ALU_RSP_CREDITS);
            rspValid <= 1'b0;
        end else begin
            credits  <= credits - CNT_W'(pop) + CNT_W'(rspCredit);
            rspValid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rsp.result <= result;
            rsp.flags  <= flags;
        end
    end

endmodule

`default_nettype wire

//--- logic/alu_pipe_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_macros.svh"

module alu_pipe_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             reqValid,
    input  alu_pkg::aluReq_t req,
    output logic             reqCredit,
    output logic             rspValid,
    output alu_pkg::aluRsp_t rsp,
    input  logic             rspCredit
);
    import alu_pkg::*;

    logic       decValid;
    decodedOp_t dec;
    logic       notEmpty;
    decodedOp_t head;
    logic       pop;

    instr_decoder i_instr_decoder (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .req      (req),
        .decValid (decValid),
        .dec      (dec)
    );

    op_queue #(
        .DEPTH (`ALU_QUEUE_DEPTH)
    ) i_op_queue (
        .clk       (clk),
        .rst       (rst),
        .decValid  (decValid),
        .dec       (dec),
        .pop       (pop),
        .notEmpty  (notEmpty),
        .head      (head),
        .reqCredit (reqCredit)   // credits back to the source
    );

    alu_execute i_alu_execute (
        .clk       (clk),
        .rst       (rst),
        .notEmpty  (notEmpty),
        .head      (head),
        .pop       (pop),
        .rspCredit (rspCredit),
        .rspValid  (rspValid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

//--- test/alu_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_macros.svh"

module alu_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             reqValid,
    input  alu_pkg::aluReq_t req,
    input  logic             reqCredit,
    input  logic             rspValid,
    input  alu_pkg::aluRsp_t rsp,
    input  logic             rspCredit,
    output int               errCount,
    output int               reqCount,
    output int               rspCount,
    output int               pendingCount
);
    import alu_pkg::*;

    aluRsp_t                    expQ [$];
    logic [`ALU_WORD_WIDTH-1:0] instrQ [$];
    aluRsp_t                    want;
    logic [`ALU_WORD_WIDTH-1:0] wantInstr;
    int                         slots;   // sink slots still open
    int                         sinceReset;

    // true when a 64-bit result does not fit in 32 signed bits
    function automatic bit outOfRange(input longint v);
        int low;
        low = int'(v[31:0]);
        return v != longint'(low);
    endfunction

    function automatic aluRsp_t expectRsp(input aluReq_t r);
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] zImm;
        longint      sa;
        longint      sb;
        aluRsp_t     e;
        opc  = r.instr[31:26];
        fn   = r.instr[5:0];
        sh   = r.instr[10:6];
        a    = r.instr[21] ? r.regB : r.regA;   // rs bit 0
        b    = r.instr[16] ? r.regB : r.regA;   // rt bit 0
        sImm = {{16{r.instr[15]}}, r.instr[15:0]};
        zImm = {16'h0000, r.instr[15:0]};
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
        e    = '0;
        if (opc == `ALU_OPC_RTYPE) begin
            case (fn)
                `ALU_FN_ADD: begin
                    e.result         = a + b;
                    e.flags.overflow = outOfRange(sa + sb);
                end
                `ALU_FN_ADDU: begin
                    e.result         = a + b;
                    e.flags.negative = e.result[31];
                end
                `ALU_FN_SUB: begin
                    e.result         = a - b;
                    e.flags.overflow = outOfRange(sa - sb);
                end
                `ALU_FN_SUBU: e.result = a - b;
                `ALU_FN_AND:  e.result = a & b;
                `ALU_FN_OR:   e.result = a | b;
                `ALU_FN_XOR:  e.result = a ^ b;
                `ALU_FN_NOR:  e.result = ~(a | b);
                `ALU_FN_SLT: begin
                    e.result         = {31'b0, sa < sb};
                    e.flags.negative = e.result[0];
                end
                `ALU_FN_SLTU: begin
                    e.result         = {31'b0, a < b};
                    e.flags.negative = e.result[0];
                end
                `ALU_FN_SLL:  e.result = b << sh;
                `ALU_FN_SRL:  e.result = b >> sh;
                `ALU_FN_SRA:  e.result = $signed(b) >>> sh;
                `ALU_FN_SLLV: e.result = b << a[4:0];
                `ALU_FN_SRLV: e.result = b >> a[4:0];
                `ALU_FN_SRAV: e.result = $signed(b) >>> a[4:0];
                default:      e.result = '0;
            endcase
        end else begin
            case (opc)
                `ALU_OPC_ADDI: begin
                    e.result         = a + sImm;
                    e.flags.overflow = outOfRange(sa + longint'($signed(sImm)));
                end
                `ALU_OPC_ADDIU: e.result = a + sImm;
                `ALU_OPC_SLTI: begin
                    e.result         = {31'b0, sa < longint'($signed(sImm))};
                    e.flags.negative = e.result[0];
                end
                `ALU_OPC_SLTIU: begin
                    e.result         = {31'b0, a < sImm};
                    e.flags.negative = e.result[0];
                end
                `ALU_OPC_ANDI: e.result = a & zImm;
                `ALU_OPC_ORI:  e.result = a | zImm;
                `ALU_OPC_XORI: e.result = a ^ zImm;
                `ALU_OPC_BEQ:  e.flags.zero = (a == b);
                `ALU_OPC_BNE:  e.flags.zero = (a != b);
                default:       e.result = '0;
            endcase
        end
        return e;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            expQ.delete();
            instrQ.delete();
            slots      = `ALU_RSP_CREDITS;
            sinceReset = 0;
        end else begin
            if (sinceReset < 16) begin
                if (rspValid || reqCredit) begin
                    $display("error at %0t: rspValid or reqCredit high %0d cycles after reset",
                             $time, sinceReset);
                    errCount++;
                end
                sinceReset++;
            end
            if (rspValid) begin
                if (slots == 0) begin
                    $display("error at %0t: response sent without a free sink slot", $time);
                    errCount++;
                end
                slots--;
                rspCount++;
                if (expQ.size() == 0) begin
                    $display("error at %0t: response arrived with no request outstanding",
                             $time);
                    errCount++;
                end else begin
                    want      = expQ.pop_front();
                    wantInstr = instrQ.pop_front();
                    if (rsp !== want) begin
                        $display("MISMATCH at %0t: instr %08h got %08h/%03b want %08h/%03b",
                                 $time, wantInstr, rsp.result, rsp.flags, want.result,
                                 want.flags);
                        errCount++;
                    end
                end
            end
            if (rspCredit) begin
                slots++;
            end
            if (reqValid) begin   // push after the pop since latency is at least 2
                expQ.push_back(expectRsp(req));
                instrQ.push_back(req.instr);
                reqCount++;
            end
        end
        pendingCount = expQ.size();
    end

endmodule

`default_nettype wire

//--- test/alu_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "alu_macros.svh"

module alu_pipe_tb;
    import alu_pkg::*;

    localparam int WAIT_LIMIT = 400;   // cycles per wait loop

    logic    clk;
    logic    rst;
    logic    reqValid;
    aluReq_t req;
    logic    reqCredit;
    logic    rspValid;
    aluRsp_t rsp;
    logic    rspCredit;
    int      errCount;
    int      reqCount;
    int      rspCount;
    int      pendingCount;

    int seed = 32'h9df8_4277;
    int srcCredits;
    int sinkHeld;    // responses taken whose credit is not yet returned
    int sinkRate;    // percent chance of a credit return per cycle
    int stallLeft;
    int errBefore;
    int localErr;
    bit hung;

    logic [5:0] arithFns [10] = '{`ALU_FN_ADD, `ALU_FN_ADDU, `ALU_FN_SUB, `ALU_FN_SUBU,
                                  `ALU_FN_AND, `ALU_FN_OR, `ALU_FN_XOR, `ALU_FN_NOR,
                                  `ALU_FN_SLT, `ALU_FN_SLTU};
    logic [5:0] shiftFns [6]  = '{`ALU_FN_SLL, `ALU_FN_SRL, `ALU_FN_SRA,
                                  `ALU_FN_SLLV, `ALU_FN_SRLV, `ALU_FN_SRAV};
    logic [5:0] iOpcs [7]     = '{`ALU_OPC_ADDI, `ALU_OPC_ADDIU, `ALU_OPC_SLTI,
                                  `ALU_OPC_SLTIU, `ALU_OPC_ANDI, `ALU_OPC_ORI, `ALU_OPC_XORI};
    logic [5:0] brOpcs [2]    = '{`ALU_OPC_BEQ, `ALU_OPC_BNE};

    alu_pipe_top i_alu_pipe_top (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (reqValid),
        .req       (req),
        .reqCredit (reqCredit),
        .rspValid  (rspValid),
        .rsp       (rsp),
        .rspCredit (rspCredit)
    );

    alu_checker aluCheck (
        .clk          (clk),
        .rst          (rst),
        .reqValid     (reqValid),
        .req          (req),
        .reqCredit    (reqCredit),
        .rspValid     (rspValid),
        .rsp          (rsp),
        .rspCredit    (rspCredit),
        .errCount     (errCount),
        .reqCount     (reqCount),
        .rspCount     (rspCount),
        .pendingCount (pendingCount)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // each falling edge collects credits, runs the sink and maybe sends
    task automatic stepCycle(input bit wantSend, input aluReq_t r, output bit sent);
        @(negedge clk);
        if (reqCredit) begin
            srcCredits++;
        end
        if (rspValid) begin
            sinkHeld++;
        end
        rspCredit = 1'b0;
        if (stallLeft > 0) begin
            stallLeft--;
        end else if (sinkHeld > 0 && randBelow(100) < sinkRate) begin
            rspCredit = 1'b1;
            sinkHeld--;
        end
        sent     = wantSend && (srcCredits > 0);
        reqValid = sent;
        if (sent) begin
            req = r;
            srcCredits--;
        end
    endtask

    task automatic sendReq(input aluReq_t r);
        int waited;
        bit sent;
        waited = 0;
        sent   = 1'b0;
        while (!sent && waited < WAIT_LIMIT) begin
            stepCycle(1'b1, r, sent);
            waited++;
        end
        if (!sent) begin
            $display("timeout: source waited %0d cycles for a request credit", WAIT_LIMIT);
            hung = 1'b1;
        end
    endtask

    task automatic drain();
        int waited;
        bit sent;
        waited = 0;
        while (!hung && pendingCount != 0 && waited < WAIT_LIMIT) begin
            stepCycle(1'b0, req, sent);
            waited++;
        end
        if (!hung && pendingCount != 0) begin
            $display("timeout: %0d responses never arrived", pendingCount);
            hung = 1'b1;
        end
    endtask

    task automatic makeInstr(input int kind, input int idx, output logic [31:0] instr);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        int          pick;
        rs    = 5'($random(seed));
        rt    = 5'($random(seed));
        rd    = 5'($random(seed));
        sh    = 5'($random(seed));
        imm   = 16'($random(seed));
        rs[0] = idx[0];   // walk the four regA/regB pairings
        rt[0] = idx[1];
        pick  = (kind == 6) ? 2 + randBelow(4) : kind;
        case (pick)
            2: instr = {`ALU_OPC_RTYPE, rs, rt, rd, sh, arithFns[randBelow(10)]};
            3: instr = {iOpcs[randBelow(7)], rs, rt, imm};
            4: begin
                if (randBelow(3) == 0) begin
                    instr = {brOpcs[randBelow(2)], rs, rt, imm};
                end else begin
                    instr = {`ALU_OPC_RTYPE, rs, rt, rd, sh, shiftFns[randBelow(6)]};
                end
            end
            default: begin
                if (randBelow(2) == 0) begin
                    instr = {1'b1, 5'($random(seed)), rs, rt, imm};   // opcodes 32..63 unused
                end else begin
                    instr = {`ALU_OPC_RTYPE, rs, rt, rd, sh, 2'b01, 4'($random(seed))};
                end
            end
        endcase
    endtask

    task automatic runTest(input int num, input string name, input int count);
        aluReq_t     r;
        logic [31:0] instr;
        errBefore = errCount;
        for (int i = 0; i < count && !hung; i++) begin
            sinkRate = (num == 6) ? 10 + randBelow(80) : 60;
            if (num == 6 && i % 30 == 10) begin
                stallLeft = 50 + randBelow(50);   // long sink stall
            end
            makeInstr(num, i, instr);
            r.instr = instr;
            r.regA  = $random(seed);
            r.regB  = (randBelow(4) == 0) ? r.regA : $random(seed);   // equal for beq/bne
            sendReq(r);
        end
        drain();
        $display("test %0d %s: %0d requests, %0d errors", num, name, count,
                 errCount - errBefore);
    endtask

    initial begin
        bit sent;
        rst        = 1'b1;
        reqValid   = 1'b0;
        req        = '0;
        rspCredit  = 1'b0;
        srcCredits = `ALU_QUEUE_DEPTH;
        sinkHeld   = 0;
        sinkRate   = 60;
        stallLeft  = 0;
        localErr   = 0;
        hung       = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errBefore = errCount;
        for (int i = 0; i < 16; i++) begin
            stepCycle(1'b0, req, sent);
        end
        $display("test 1 idle after reset: 0 requests, %0d errors", errCount - errBefore);

        runTest(2, "R-type arithmetic, logic and compare", 64);
        runTest(3, "I-type with extension", 48);
        runTest(4, "shifts and branches", 48);
        runTest(5, "unlisted codes", 32);
        runTest(6, "random back-pressure", 120);

        if (reqCount != rspCount) begin
            $display("error: %0d requests but %0d responses", reqCount, rspCount);
            localErr++;
        end
        if (!hung && srcCredits != `ALU_QUEUE_DEPTH) begin
            $display("error: source ends with %0d credits", srcCredits);
            localErr++;
        end
        $display("summary: %0d requests, %0d responses, %0d errors", reqCount, rspCount,
                 errCount + localErr);
        if (errCount + localErr == 0 && !hung) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- alu_pipe.f
+incdir+logic
logic/alu_pkg.sv
logic/instr_decoder.sv
logic/op_queue.sv
logic/alu_execute.sv
logic/alu_pipe_top.sv
test/alu_checker.sv
test/alu_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the ALU pipeline testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -f alu_pipe.f --top-module alu_pipe_tb -o alu_pipe_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/alu_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    exit 1
fi
exit 0
